//--- rsAluTop.f
+incdir+include
verilog/rsPkg.sv
verilog/rsIfs.sv
verilog/wakeupMatch.sv
verilog/rsDispatchStage.sv
verilog/rsEntryStore.sv
verilog/issueSelect.sv
verilog/rsAluTop.sv
tb/clockGen.sv
tb/rsAluChecker.sv
tb/rsAluTb.sv

//--- run.sh
#!/bin/sh
# build and run the reservation station testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rsAluTop.f \
    --top-module rsAluTb \
    -o rsAluSim \
    && ./obj_dir/rsAluSim \
    || exit 1

//--- include/rsAluModel.svh
`ifndef RS_ALU_MODEL_SVH
`define RS_ALU_MODEL_SVH

// scoreboard, keyed by instNum; an edge of -1 means not yet ready
int dispEdge [int];
int rdy1Edge [int];
int rdy2Edge [int];
bit issuedFlag [int];

// payload derived from the sequence number alone
function automatic rsPkg::aluPayloadT expectedPayload(input int num);
    rsPkg::aluPayloadT p;
    p.instNum = num;
    p.rd = 8'(num + 1);
    p.memToReg = num[0];
    p.memRead = num[1];
    p.memWrite = num[2];
    p.aluOp = num[6:3];
    p.aluSrc2 = num[7];
    p.funct3 = num[10:8];
    p.imm = num ^ 32'h5a5a_0000;
    return p;
endfunction

// tags kept in a small pool so random broadcasts hit often
function automatic rsPkg::tagT expectedSrc1(input int num);
    return rsPkg::tagT'((num * 7 + 3) % 32);
endfunction

function automatic rsPkg::tagT expectedSrc2(input int num);
    return rsPkg::tagT'((num * 13 + 5) % 32);
endfunction

// any valid result bus with this tag, sampled at the current edge
function automatic bit bcastHit(input rsPkg::tagT tag);
    return (aluResultValid && aluResultTag == tag) ||
           (mulResultValid && mulResultTag == tag) ||
           (loadResultValid && loadResultTag == tag);
endfunction

// earliest edge this operation may legally issue at
function automatic int earliestIssue(input int num);
    int e;
    e = dispEdge[num] + 2;
    if (rdy1Edge[num] + 1 > e) e = rdy1Edge[num] + 1;
    if (rdy2Edge[num] + 1 > e) e = rdy2Edge[num] + 1;
    return e;
endfunction

`endif

//--- tb/rsAluTb.sv
`default_nettype none

module rsAluTb;

    localparam int ClockPeriod = 40;
    localparam int TotalOps = 317;
    localparam int OpCycles = 200;    // generous bound per operation

    logic clk, reset, start, src1Ready, src2Ready;
    rsPkg::tagT src1, src2, rd, aluResultTag, mulResultTag, loadResultTag;
    logic [31:0] instNum, imm, issueInstNum, issueImm;
    logic memToReg, memRead, memWrite, aluSrc2;
    logic [3:0] aluOp, issueAluOp;
    logic [2:0] funct3, issueFunct3;
    logic aluResultValid, mulResultValid, loadResultValid;
    logic full, issueValid, issueMemToReg, issueMemRead, issueMemWrite, issueAluSrc2;
    rsPkg::tagT issueSrc1, issueSrc2, issueRd;
    int cycle = 0;
    int issuedCount = 0;
    int orderQ [$];
    bit randomOn = 0;

    `include "rsAluModel.svh"

    clockGen #(.Period(ClockPeriod), .ResetCycles(4)) clocks (.clk(clk), .reset(reset));

    rsAluTop #(.Entries(16), .Window(8)) DUT (.*);

    task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            $display("TEST RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic failRun(input string what);
        $display("%0t %s", $time, what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic setBcast(input int bus, input logic v, input rsPkg::tagT tag);
        case (bus)
            0: begin
                aluResultValid <= v;
                aluResultTag <= tag;
            end
            1: begin
                mulResultValid <= v;
                mulResultTag <= tag;
            end
            default: begin
                loadResultValid <= v;
                loadResultTag <= tag;
            end
        endcase
    endtask

    // wakeBus below 3 also broadcasts src1 in the dispatch cycle
    task automatic dispatchOp(input int num, input logic r1, input logic r2, input int wakeBus);
        rsPkg::aluPayloadT p;
        p = expectedPayload(num);
        @(negedge clk);
        while (full) @(negedge clk);
        @(posedge clk);
        start <= 1'b1;
        src1 <= expectedSrc1(num);
        src2 <= expectedSrc2(num);
        src1Ready <= r1;
        src2Ready <= r2;
        {instNum, rd, memToReg, memRead, memWrite, aluOp, aluSrc2, funct3, imm} <= p;
        if (wakeBus < 3) setBcast(wakeBus, 1'b1, expectedSrc1(num));
        @(posedge clk);
        start <= 1'b0;
        if (wakeBus < 3) setBcast(wakeBus, 1'b0, '0);
    endtask

    task automatic pulseBcast(input int bus, input rsPkg::tagT tag);
        @(posedge clk);
        setBcast(bus, 1'b1, tag);
        @(posedge clk);
        setBcast(bus, 1'b0, '0);
    endtask

    task automatic waitIssued(input int target);
        while (issuedCount < target) @(negedge clk);
    endtask

    task automatic checkIssue(input int edgeNum);
        rsPkg::aluPayloadT p;
        int num;
        num = issueInstNum;
        if (!dispEdge.exists(num)) failRun("issued an operation that was never dispatched");
        if (issuedFlag.exists(num)) failRun("issued the same operation twice");
        p = expectedPayload(num);
        checkValue("issueSrc1", 64'(expectedSrc1(num)), 64'(issueSrc1));
        checkValue("issueSrc2", 64'(expectedSrc2(num)), 64'(issueSrc2));
        checkValue("issueRd", 64'(p.rd), 64'(issueRd));
        checkValue("issueMemToReg", 64'(p.memToReg), 64'(issueMemToReg));
        checkValue("issueMemRead", 64'(p.memRead), 64'(issueMemRead));
        checkValue("issueMemWrite", 64'(p.memWrite), 64'(issueMemWrite));
        checkValue("issueAluOp", 64'(p.aluOp), 64'(issueAluOp));
        checkValue("issueAluSrc2", 64'(p.aluSrc2), 64'(issueAluSrc2));
        checkValue("issueFunct3", 64'(p.funct3), 64'(issueFunct3));
        checkValue("issueImm", 64'(p.imm), 64'(issueImm));
        if (rdy1Edge[num] < 0 || rdy2Edge[num] < 0 || edgeNum < earliestIssue(num)) begin
            failRun("issued an operation before its operands were ready");
        end
        if (orderQ.size() > 0) checkValue("issueInstNum", 64'(orderQ.pop_front()), 64'(num));
        issuedFlag[num] = 1'b1;
        issuedCount++;
    endtask

    // compare process; values read at the edge are the ones the DUT samples
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!reset) begin
            if (issueValid) checkIssue(cycle - 1);    // registered at the previous edge
            if (start) begin
                dispEdge[instNum] = cycle;
                rdy1Edge[instNum] = src1Ready ? cycle : -1;
                rdy2Edge[instNum] = src2Ready ? cycle : -1;
            end
            foreach (dispEdge[n]) begin
                if (rdy1Edge[n] < 0 && bcastHit(expectedSrc1(n))) rdy1Edge[n] = cycle;
                if (rdy2Edge[n] < 0 && bcastHit(expectedSrc2(n))) rdy2Edge[n] = cycle;
            end
        end
    end

    always @(posedge clk) begin
        if (randomOn) begin
            aluResultValid <= 1'($urandom % 2);
            aluResultTag <= rsPkg::tagT'($urandom % 32);
            mulResultValid <= 1'($urandom % 2);
            mulResultTag <= rsPkg::tagT'($urandom % 32);
            loadResultValid <= 1'($urandom % 2);
            loadResultTag <= rsPkg::tagT'($urandom % 32);
        end
    end

    initial begin
        #(TotalOps * OpCycles * ClockPeriod);
        $display("timeout: operations did not all issue in time");
        $display("TEST RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        void'($urandom(76));
        {start, src1, src2, src1Ready, src2Ready} = '0;
        {instNum, rd, memToReg, memRead, memWrite, aluOp, aluSrc2, funct3, imm} = '0;
        {aluResultValid, aluResultTag, mulResultValid, mulResultTag} = '0;
        {loadResultValid, loadResultTag} = '0;

        repeat (14) begin
            @(negedge clk);
            checkValue("issueValid", 64'(0), 64'(issueValid));
            checkValue("full", 64'(0), 64'(full));
        end

        for (int n = 1; n <= 4; n++) begin
            orderQ.push_back(n);
            dispatchOp(n, 1'b1, 1'b1, 3);
        end
        waitIssued(4);

        // invalid broadcast must not wake but the mul bus must
        dispatchOp(100, 1'b0, 1'b1, 3);
        @(posedge clk);
        setBcast(0, 1'b0, expectedSrc1(100));
        repeat (10) @(negedge clk);
        checkValue("issuedCount", 64'(4), 64'(issuedCount));
        pulseBcast(1, expectedSrc1(100));
        waitIssued(5);
        dispatchOp(101, 1'b0, 1'b1, 2);
        waitIssued(6);

        // younger ready entry passes an older waiting one
        dispatchOp(200, 1'b0, 1'b1, 3);
        orderQ.push_back(201);
        dispatchOp(201, 1'b1, 1'b1, 3);
        waitIssued(7);
        orderQ.push_back(200);
        pulseBcast(0, expectedSrc1(200));
        waitIssued(8);

        // 308 sits one slot past the window
        dispatchOp(300, 1'b0, 1'b1, 3);
        for (int n = 301; n <= 308; n++) begin
            if (n < 308) orderQ.push_back(n);
            dispatchOp(n, 1'b1, 1'b1, 3);
        end
        waitIssued(15);
        repeat (12) @(negedge clk);
        checkValue("issuedCount", 64'(15), 64'(issuedCount));
        orderQ.push_back(300);
        orderQ.push_back(308);
        pulseBcast(2, expectedSrc1(300));
        waitIssued(17);

        randomOn = 1'b1;
        for (int i = 0; i < 300; i++) begin
            dispatchOp(1000 + i, 1'($urandom % 2), 1'($urandom % 2), 3);
        end
        waitIssued(TotalOps);
        randomOn = 1'b0;
        repeat (4) @(negedge clk);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/rsAluChecker.sv
`default_nettype none

module rsAluChecker (
    input logic clk,
    input logic reset,
    input logic start,
    input logic full,
    input logic issueValid
);

    logic fullQ;
    int unspentIssues;    // each fall of full uses up one issue that freed a slot

    always @(posedge clk) begin
        if (reset) begin
            fullQ <= 1'b0;
            unspentIssues <= 0;
        end else begin
            fullQ <= full;
            unspentIssues <= unspentIssues + int'(issueValid) - int'(fullQ && !full);
        end
    end

    issueKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(issueValid))
        else $error("issueValid is unknown");

    noStartWhenFull: assert property (@(posedge clk) disable iff (reset) !(start && full))
        else $error("start asserted while full");

    fullFallsAfterIssue: assert property (@(posedge clk) disable iff (reset)
        $fell(full) |-> unspentIssues > 0)
        else $error("full dropped with no issue");

endmodule

bind rsAluTop rsAluChecker protocolCheck (
    .clk(clk),
    .reset(reset),
    .start(start),
    .full(full),
    .issueValid(issueValid)
);

`default_nettype wire

//--- tb/clockGen.sv
`default_nettype none

module clockGen #(
    parameter int Period = 40,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;    // released on an edge like every other input
    end

endmodule

`default_nettype wire

//--- verilog/rsAluTop.sv
`default_nettype none

module rsAluTop #(
    parameter int Entries = rsPkg::DefaultEntries,
    parameter int Window = rsPkg::DefaultWindow
) (
    input logic clk,
    input logic reset,
    input logic start,
    input rsPkg::tagT src1,
    input rsPkg::tagT src2,
    input logic src1Ready,
    input logic src2Ready,
    input logic [rsPkg::InstNumWidth-1:0] instNum,
    input rsPkg::tagT rd,
    input logic memToReg,
    input logic memRead,
    input logic memWrite,
    input logic [rsPkg::AluOpWidth-1:0] aluOp,
    input logic aluSrc2,
    input logic [2:0] funct3,
    input logic [rsPkg::ImmWidth-1:0] imm,
    input logic aluResultValid,
    input rsPkg::tagT aluResultTag,
    input logic mulResultValid,
    input rsPkg::tagT mulResultTag,
    input logic loadResultValid,
    input rsPkg::tagT loadResultTag,
    output logic full,
    output logic issueValid,
    output rsPkg::tagT issueSrc1,
    output rsPkg::tagT issueSrc2,
    output logic [rsPkg::InstNumWidth-1:0] issueInstNum,
    output rsPkg::tagT issueRd,
    output logic issueMemToReg,
    output logic issueMemRead,
    output logic issueMemWrite,
    output logic [rsPkg::AluOpWidth-1:0] issueAluOp,
    output logic issueAluSrc2,
    output logic [2:0] issueFunct3,
    output logic [rsPkg::ImmWidth-1:0] issueImm
);

    rsPkg::broadcastT [rsPkg::NumBroadcasts-1:0] bcast;
    rsPkg::aluPayloadT payload;
    rsPkg::aluPayloadT issuePayload;

    dispatchIf #(.payloadT(rsPkg::aluPayloadT)) dispatchBus ();
    issueWindowIf #(.Window(Window), .payloadT(rsPkg::aluPayloadT)) windowBus ();

    assign bcast[rsPkg::BcastAlu] = '{valid: aluResultValid, tag: aluResultTag};
    assign bcast[rsPkg::BcastMul] = '{valid: mulResultValid, tag: mulResultTag};
    assign bcast[rsPkg::BcastLoad] = '{valid: loadResultValid, tag: loadResultTag};

    assign payload = '{
        instNum: instNum,
        rd: rd,
        memToReg: memToReg,
        memRead: memRead,
        memWrite: memWrite,
        aluOp: aluOp,
        aluSrc2: aluSrc2,
        funct3: funct3,
        imm: imm
    };

    rsDispatchStage dispatchStage (
        .clk(clk),
        .reset(reset),
        .start(start),
        .src1(src1),
        .src2(src2),
        .src1Ready(src1Ready),
        .src2Ready(src2Ready),
        .payload(payload),
        .bcast(bcast),
        .dispatchOut(dispatchBus.source)
    );

    rsEntryStore #(
        .Entries(Entries),
        .Window(Window),
        .payloadT(rsPkg::aluPayloadT)
    ) entryStore (
        .clk(clk),
        .reset(reset),
        .dispatchIn(dispatchBus.sink),
        .bcast(bcast),
        .window(windowBus.store),
        .full(full)
    );

    issueSelect #(
        .Window(Window),
        .payloadT(rsPkg::aluPayloadT)
    ) select (
        .clk(clk),
        .reset(reset),
        .window(windowBus.select),
        .issueValid(issueValid),
        .issueSrc1(issueSrc1),
        .issueSrc2(issueSrc2),
        .issuePayload(issuePayload)
    );

    assign issueInstNum = issuePayload.instNum;
    assign issueRd = issuePayload.rd;
    assign issueMemToReg = issuePayload.memToReg;
    assign issueMemRead = issuePayload.memRead;
    assign issueMemWrite = issuePayload.memWrite;
    assign issueAluOp = issuePayload.aluOp;
    assign issueAluSrc2 = issuePayload.aluSrc2;
    assign issueFunct3 = issuePayload.funct3;
    assign issueImm = issuePayload.imm;

endmodule

`default_nettype wire

//--- verilog/issueSelect.sv
`default_nettype none

module issueSelect #(
    parameter int Window = rsPkg::DefaultWindow,
    parameter type payloadT = rsPkg::aluPayloadT
) (
    input logic clk,
    input logic reset,
    issueWindowIf.select window,
    output logic issueValid,
    output rsPkg::tagT issueSrc1,
    output rsPkg::tagT issueSrc2,
    output payloadT issuePayload
);

    localparam int OffsetWidth = rsPkg::offsetWidth(Window);

    // lowest offset wins, so scan from the top down
    always_comb begin
        window.grantValid = 1'b0;
        window.grantOffset = '0;
        for (int k = Window - 1; k >= 0; k--) begin
            if (window.windowReady[k]) begin
                window.grantValid = 1'b1;
                window.grantOffset = OffsetWidth'(k);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= window.grantValid;
        end
    end

    always_ff @(posedge clk) begin
        if (window.grantValid) begin
            issueSrc1 <= window.windowEntry[window.grantOffset].src1;
            issueSrc2 <= window.windowEntry[window.grantOffset].src2;
            issuePayload <= window.windowEntry[window.grantOffset].payload;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rsEntryStore.sv
`default_nettype none

module rsEntryStore #(
    parameter int Entries = rsPkg::DefaultEntries,
    parameter int Window = rsPkg::DefaultWindow,
    parameter type payloadT = rsPkg::aluPayloadT
) (
    input logic clk,
    input logic reset,
    dispatchIf.sink dispatchIn,
    input rsPkg::broadcastT [rsPkg::NumBroadcasts-1:0] bcast,
    issueWindowIf.store window,
    output logic full
);

    localparam int PtrWidth = $clog2(Entries);

    logic [Entries-1:0] live;
    logic [Entries-1:0] rdy1;
    logic [Entries-1:0] rdy2;
    logic [Entries-1:0] hit1;
    logic [Entries-1:0] hit2;
    rsPkg::tagT src1Tag [Entries];
    rsPkg::tagT src2Tag [Entries];
    payloadT payloadMem [Entries];
    logic wrHit1;
    logic wrHit2;
    logic [PtrWidth-1:0] head;
    logic [PtrWidth-1:0] tail;
    logic [PtrWidth-1:0] used;
    logic [PtrWidth-1:0] grantSlot;

    // write port sees the broadcasts of its own write edge
    wakeupMatch wrMatch1 (
        .tag(dispatchIn.src1),
        .bcast(bcast),
        .hit(wrHit1)
    );

    wakeupMatch wrMatch2 (
        .tag(dispatchIn.src2),
        .bcast(bcast),
        .hit(wrHit2)
    );

    for (genvar i = 0; i < Entries; i++) begin : gEntry
        wakeupMatch match1 (
            .tag(src1Tag[i]),
            .bcast(bcast),
            .hit(hit1[i])
        );

        wakeupMatch match2 (
            .tag(src2Tag[i]),
            .bcast(bcast),
            .hit(hit2[i])
        );
    end

    assign grantSlot = head + PtrWidth'(window.grantOffset);
    assign used = tail - head;

    // one slot stays empty; the write still sitting in the dispatch register counts too
    assign full = (used == PtrWidth'(Entries - 1)) ||
                  (dispatchIn.valid && used == PtrWidth'(Entries - 2));

    always_ff @(posedge clk) begin
        if (reset) begin
            live <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (window.grantValid) begin
                live[grantSlot] <= 1'b0;
            end
            if (dispatchIn.valid) begin
                live[tail] <= 1'b1;
                tail <= tail + 1'b1;
            end
            if (head != tail && !live[head]) begin
                head <= head + 1'b1;    // step over an issued slot
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < Entries; i++) begin
            if (hit1[i]) begin
                rdy1[i] <= 1'b1;
            end
            if (hit2[i]) begin
                rdy2[i] <= 1'b1;
            end
        end
        if (dispatchIn.valid) begin
            src1Tag[tail] <= dispatchIn.src1;
            src2Tag[tail] <= dispatchIn.src2;
            rdy1[tail] <= dispatchIn.ready1 | wrHit1;
            rdy2[tail] <= dispatchIn.ready2 | wrHit2;
            payloadMem[tail] <= dispatchIn.payload;
        end
    end

    // window of Window slots starting at head
    always_comb begin
        logic [PtrWidth-1:0] slot;
        for (int k = 0; k < Window; k++) begin
            slot = head + PtrWidth'(k);
            window.windowReady[k] = live[slot] & rdy1[slot] & rdy2[slot];
            window.windowEntry[k] = '{
                payload: payloadMem[slot],
                src1: src1Tag[slot],
                src2: src2Tag[slot]
            };
        end
    end

endmodule

`default_nettype wire

//--- verilog/rsDispatchStage.sv
`default_nettype none

module rsDispatchStage (
    input logic clk,
    input logic reset,
    input logic start,
    input rsPkg::tagT src1,
    input rsPkg::tagT src2,
    input logic src1Ready,
    input logic src2Ready,
    input rsPkg::aluPayloadT payload,
    input rsPkg::broadcastT [rsPkg::NumBroadcasts-1:0] bcast,
    dispatchIf.source dispatchOut
);

    logic hit1;
    logic hit2;

    // a result seen in the dispatch cycle would otherwise be missed
    wakeupMatch match1 (
        .tag(src1),
        .bcast(bcast),
        .hit(hit1)
    );

    wakeupMatch match2 (
        .tag(src2),
        .bcast(bcast),
        .hit(hit2)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            dispatchOut.valid <= 1'b0;
        end else begin
            dispatchOut.valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dispatchOut.src1 <= src1;
            dispatchOut.src2 <= src2;
            dispatchOut.ready1 <= src1Ready | hit1;
            dispatchOut.ready2 <= src2Ready | hit2;
            dispatchOut.payload <= payload;
        end
    end

endmodule

`default_nettype wire

//--- verilog/wakeupMatch.sv
`default_nettype none

// any valid result bus carrying this tag
module wakeupMatch (
    input rsPkg::tagT tag,
    input rsPkg::broadcastT [rsPkg::NumBroadcasts-1:0] bcast,
    output logic hit
);

    always_comb begin
        hit = 1'b0;
        for (int b = 0; b < rsPkg::NumBroadcasts; b++) begin
            if (bcast[b].valid && bcast[b].tag == tag) begin
                hit = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rsIfs.sv
`default_nettype none

// registered dispatch, one pulse on valid per operation
interface dispatchIf #(
    parameter type payloadT = rsPkg::aluPayloadT
);
    logic valid;
    rsPkg::tagT src1;
    rsPkg::tagT src2;
    logic ready1;
    logic ready2;
    payloadT payload;

    modport source (output valid, src1, src2, ready1, ready2, payload);
    modport sink (input valid, src1, src2, ready1, ready2, payload);
endinterface

interface issueWindowIf #(
    parameter int Window = rsPkg::DefaultWindow,
    parameter type payloadT = rsPkg::aluPayloadT
);
    typedef struct packed {
        payloadT payload;
        rsPkg::tagT src1;
        rsPkg::tagT src2;
    } windowEntryT;

    logic [Window-1:0] windowReady;   // bit k is entry head+k
    windowEntryT windowEntry [Window];
    logic grantValid;
    logic [rsPkg::offsetWidth(Window)-1:0] grantOffset;

    modport store (output windowReady, windowEntry, input grantValid, grantOffset);
    modport select (input windowReady, windowEntry, output grantValid, grantOffset);
endinterface

`default_nettype wire

//--- verilog/rsPkg.sv
`default_nettype none

package rsPkg;

    localparam int TagWidth = 8;
    localparam int InstNumWidth = 32;
    localparam int ImmWidth = 32;
    localparam int AluOpWidth = 4;

    localparam int NumBroadcasts = 3;
    localparam int BcastAlu = 0;    // slot order inside the broadcast array
    localparam int BcastMul = 1;
    localparam int BcastLoad = 2;

    localparam int DefaultEntries = 16;
    localparam int DefaultWindow = 8;

    typedef logic [TagWidth-1:0] tagT;

    // one result bus
    typedef struct packed {
        logic valid;
        tagT tag;
    } broadcastT;

    // 83 bits travel with each operation
    typedef struct packed {
        logic [InstNumWidth-1:0] instNum;
        tagT rd;
        logic memToReg;
        logic memRead;
        logic memWrite;
        logic [AluOpWidth-1:0] aluOp;
        logic aluSrc2;
        logic [2:0] funct3;
        logic [ImmWidth-1:0] imm;
    } aluPayloadT;

    // width of an offset into the selection window
    function automatic int offsetWidth(int window);
        return (window > 1) ? $clog2(window) : 1;
    endfunction

endpackage

`default_nettype wire
